// File: rtl/mem_pkg.sv
package mem_pkg;

  typedef logic [31:0] word_t;
  typedef logic [3:0]  strb_t;
  typedef logic [4:0]  mem_opcode_t;
  typedef logic [2:0]  excp_t;
  typedef logic [1:0]  plv_t;
  typedef logic [19:0] vpn_t;
  typedef logic [19:0] ppn_t;
  typedef logic [2:0]  cfg_idx_t;

  // Bit positions inside mem_opcode_t.
  localparam int OP_STORE     = 0;
  localparam int OP_SIZE_BYTE = 1;
  localparam int OP_SIZE_HALF = 2;
  localparam int OP_SIZE_WORD = 3;
  localparam int OP_LOAD_SIGN = 4;

  localparam excp_t EXC_ALE  = 3'd0;
  localparam excp_t EXC_TLBR = 3'd1;
  localparam excp_t EXC_PIL  = 3'd2;
  localparam excp_t EXC_PIS  = 3'd3;
  localparam excp_t EXC_PPI  = 3'd4;
  localparam excp_t EXC_PME  = 3'd5;

  localparam cfg_idx_t CFG_PLV   = 3'd0;
  localparam cfg_idx_t CFG_DMW   = 3'd1;
  localparam cfg_idx_t CFG_PAGE0 = 3'd2;
  localparam cfg_idx_t CFG_PAGE1 = 3'd3;
  localparam cfg_idx_t CFG_PAGE2 = 3'd4;
  localparam cfg_idx_t CFG_PAGE3 = 3'd5;

  // Fields of the CFG_DMW value.
  localparam int DMW_EN_BIT   = 0;
  localparam int DMW_PSEG_LSB = 25;
  localparam int DMW_VSEG_LSB = 29;

  // Fields of a CFG_PAGEn value. The ppn field is narrow and zero-extended.
  localparam int PG_VALID_BIT = 0;
  localparam int PG_DIRTY_BIT = 1;
  localparam int PG_PLV_LSB   = 2;
  localparam int PG_PPN_LSB   = 4;
  localparam int PG_PPN_W     = 8;
  localparam int PG_VPN_LSB   = 12;

endpackage

// File: rtl/lsu.sv
`timescale 1ns/1ns

module lsu (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 cancel,
  output logic                 ready,
  input  logic                 valid,
  input  logic                 start,
  input  mem_pkg::word_t       addr,
  input  mem_pkg::mem_opcode_t opcode,
  input  mem_pkg::word_t       st_data,
  output logic                 have_excp,
  output mem_pkg::excp_t       excp_type,
  output logic                 ok,
  input  logic                 accept_ok,
  output mem_pkg::word_t       ld_data,
  output logic                 mmu_req,
  output mem_pkg::word_t       mmu_addr,
  output logic                 mmu_we,
  output logic [1:0]           mmu_size,
  output mem_pkg::strb_t       mmu_wstrb,
  output mem_pkg::word_t       mmu_wdata,
  input  logic                 mmu_addr_ok,
  input  logic                 mmu_data_ok,
  input  mem_pkg::word_t       mmu_rdata,
  input  logic                 mmu_tlbr,
  input  logic                 mmu_pil,
  input  logic                 mmu_pis,
  input  logic                 mmu_ppi,
  input  logic                 mmu_pme
);
  import mem_pkg::*;

  logic        wait_for_addr_ok;
  logic        wait_for_data_ok;
  logic        ok_not_accepted;
  word_t       ld_data_buf;
  logic [1:0]  addr_lowbit_buf;
  mem_opcode_t opcode_buf;
  word_t       ld_data_inner;
  logic        stage2_allowin;
  logic        misaligned;

  // ==================================================
  // Request tracking
  // ==================================================
  // A new address may only be accepted if its answer will find a free result slot.
  assign stage2_allowin = (!wait_for_data_ok || mmu_data_ok) && (!ok || accept_ok);

  assign mmu_req = (start || wait_for_addr_ok) && stage2_allowin;

  assign ready = !((wait_for_addr_ok || start && !cancel) && !mmu_addr_ok)
                 && (!ok || accept_ok); // Low while a request or result is stuck.

  always_ff @(posedge clk) begin
    if (reset) begin
      wait_for_addr_ok <= 1'b0;
    end else if (mmu_addr_ok) begin
      wait_for_addr_ok <= 1'b0;
    end else if (start && !cancel) begin
      wait_for_addr_ok <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wait_for_data_ok <= 1'b0;
    end else if (mmu_addr_ok) begin
      wait_for_data_ok <= 1'b1;
    end else if (mmu_data_ok) begin
      wait_for_data_ok <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (mmu_addr_ok) begin
      addr_lowbit_buf <= mmu_addr[1:0]; // Needed to align the returning word.
      opcode_buf      <= opcode;
    end
  end

  // ==================================================
  // Result holding
  // ==================================================
  assign ok      = mmu_data_ok || ok_not_accepted;
  assign ld_data = ok_not_accepted ? ld_data_buf : ld_data_inner;

  always_ff @(posedge clk) begin
    if (reset) begin
      ok_not_accepted <= 1'b0;
    end else if (mmu_data_ok && !accept_ok) begin
      ok_not_accepted <= 1'b1;
    end else if (accept_ok) begin
      ok_not_accepted <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (mmu_data_ok && !accept_ok) begin
      ld_data_buf <= ld_data_inner;
    end
  end

  // ==================================================
  // Store formatting
  // ==================================================
  assign mmu_addr = addr;
  assign mmu_we   = opcode[OP_STORE];
  assign mmu_size = opcode[OP_SIZE_BYTE] ? 2'd0 : opcode[OP_SIZE_HALF] ? 2'd1 : 2'd2;

  always_comb begin
    mmu_wstrb = 4'b0000;
    mmu_wdata = st_data;
    if (opcode[OP_STORE]) begin
      if (opcode[OP_SIZE_BYTE]) begin
        mmu_wstrb = 4'b0001 << addr[1:0];
        mmu_wdata = {4{st_data[7:0]}}; // Byte lanes all carry the same byte.
      end else if (opcode[OP_SIZE_HALF]) begin
        mmu_wstrb = addr[1] ? 4'b1100 : 4'b0011;
        mmu_wdata = {2{st_data[15:0]}};
      end else begin
        mmu_wstrb = 4'b1111;
      end
    end
  end

  // ==================================================
  // Exceptions
  // ==================================================
  assign misaligned = opcode[OP_SIZE_HALF] && addr[0]
                      || opcode[OP_SIZE_WORD] && addr[1:0] != 2'b00;

  always_comb begin
    have_excp = valid;
    excp_type = EXC_ALE;
    if (!valid || misaligned) begin
      excp_type = EXC_ALE; // Alignment wins over every translation fault.
    end else if (mmu_tlbr) begin
      excp_type = EXC_TLBR;
    end else if (mmu_pil) begin
      excp_type = EXC_PIL;
    end else if (mmu_pis) begin
      excp_type = EXC_PIS;
    end else if (mmu_ppi) begin
      excp_type = EXC_PPI;
    end else if (mmu_pme) begin
      excp_type = EXC_PME;
    end else begin
      have_excp = 1'b0;
    end
  end

  // ==================================================
  // Load alignment
  // ==================================================
  always_comb begin
    logic [7:0]  load_b;
    logic [15:0] load_h;
    load_b = mmu_rdata[8*addr_lowbit_buf +: 8];
    load_h = addr_lowbit_buf[1] ? mmu_rdata[31:16] : mmu_rdata[15:0];
    if (opcode_buf[OP_SIZE_BYTE]) begin
      ld_data_inner = {{24{load_b[7] && opcode_buf[OP_LOAD_SIGN]}}, load_b};
    end else if (opcode_buf[OP_SIZE_HALF]) begin
      ld_data_inner = {{16{load_h[15] && opcode_buf[OP_LOAD_SIGN]}}, load_h};
    end else begin
      ld_data_inner = mmu_rdata;
    end
  end

endmodule

// File: rtl/mmu_csr.sv
`timescale 1ns/1ns

module mmu_csr #(
  parameter int MAP_ENTRIES = 4
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   cfg_we,
  input  mem_pkg::cfg_idx_t      cfg_idx,
  input  mem_pkg::word_t         cfg_wdata,
  output mem_pkg::plv_t          plv,
  output logic                   dmw_en,
  output logic [2:0]             dmw_vseg,
  output logic [2:0]             dmw_pseg,
  output mem_pkg::vpn_t          page_vpn [MAP_ENTRIES],
  output mem_pkg::ppn_t          page_ppn [MAP_ENTRIES],
  output logic [MAP_ENTRIES-1:0] page_valid,
  output logic [MAP_ENTRIES-1:0] page_dirty,
  output mem_pkg::plv_t          page_plv [MAP_ENTRIES]
);
  import mem_pkg::*;

  always_ff @(posedge clk) begin
    if (reset) begin
      plv        <= '0; // Start in the most privileged level.
      dmw_en     <= 1'b0;
      dmw_vseg   <= '0;
      dmw_pseg   <= '0;
      page_valid <= '0;
      page_dirty <= '0;
      for (int i = 0; i < MAP_ENTRIES; i++) begin
        page_vpn[i] <= '0;
        page_ppn[i] <= '0;
        page_plv[i] <= '0;
      end
    end else if (cfg_we) begin
      if (cfg_idx == CFG_PLV) begin
        plv <= cfg_wdata[1:0];
      end
      if (cfg_idx == CFG_DMW) begin
        dmw_en   <= cfg_wdata[DMW_EN_BIT];
        dmw_vseg <= cfg_wdata[DMW_VSEG_LSB +: 3];
        dmw_pseg <= cfg_wdata[DMW_PSEG_LSB +: 3];
      end
      for (int i = 0; i < MAP_ENTRIES; i++) begin
        if (cfg_idx == cfg_idx_t'(CFG_PAGE0 + i)) begin
          page_vpn[i]   <= cfg_wdata[PG_VPN_LSB +: 20];
          page_ppn[i]   <= ppn_t'(cfg_wdata[PG_PPN_LSB +: PG_PPN_W]);
          page_plv[i]   <= cfg_wdata[PG_PLV_LSB +: 2];
          page_valid[i] <= cfg_wdata[PG_VALID_BIT];
          page_dirty[i] <= cfg_wdata[PG_DIRTY_BIT];
        end
      end
    end
  end

endmodule

// File: rtl/mmu.sv
`timescale 1ns/1ns

module mmu #(
  parameter int MAP_ENTRIES = 4
) (
  input  logic                   mmu_req,
  input  mem_pkg::word_t         mmu_addr,
  input  logic                   mmu_we,
  input  logic [1:0]             mmu_size,
  input  mem_pkg::strb_t         mmu_wstrb,
  input  mem_pkg::word_t         mmu_wdata,
  output logic                   mmu_addr_ok,
  output logic                   mmu_data_ok,
  output mem_pkg::word_t         mmu_rdata,
  output logic                   mmu_tlbr,
  output logic                   mmu_pil,
  output logic                   mmu_pis,
  output logic                   mmu_ppi,
  output logic                   mmu_pme,
  input  mem_pkg::plv_t          plv,
  input  logic                   dmw_en,
  input  logic [2:0]             dmw_vseg,
  input  logic [2:0]             dmw_pseg,
  input  mem_pkg::vpn_t          page_vpn [MAP_ENTRIES],
  input  mem_pkg::ppn_t          page_ppn [MAP_ENTRIES],
  input  logic [MAP_ENTRIES-1:0] page_valid,
  input  logic [MAP_ENTRIES-1:0] page_dirty,
  input  mem_pkg::plv_t          page_plv [MAP_ENTRIES],
  output logic                   ram_req,
  output mem_pkg::word_t         ram_addr,
  output logic                   ram_we,
  output mem_pkg::strb_t         ram_wstrb,
  output mem_pkg::word_t         ram_wdata,
  input  logic                   ram_addr_ok,
  input  logic                   ram_data_ok,
  input  mem_pkg::word_t         ram_rdata
);
  import mem_pkg::*;

  logic  dmw_hit;
  logic  any_hit;
  logic  sel_valid;
  logic  sel_dirty;
  plv_t  sel_plv;
  ppn_t  sel_ppn;
  logic  mapped;
  logic  misaligned;

  assign dmw_hit = dmw_en && mmu_addr[31:29] == dmw_vseg;

  // Lowest matching entry wins.
  always_comb begin
    any_hit   = 1'b0;
    sel_valid = 1'b0;
    sel_dirty = 1'b0;
    sel_plv   = '0;
    sel_ppn   = '0;
    for (int i = MAP_ENTRIES - 1; i >= 0; i--) begin
      if (page_vpn[i] == mmu_addr[31:12]) begin
        any_hit   = 1'b1;
        sel_valid = page_valid[i];
        sel_dirty = page_dirty[i];
        sel_plv   = page_plv[i];
        sel_ppn   = page_ppn[i];
      end
    end
  end

  assign mapped   = !dmw_hit && any_hit && sel_valid;
  assign mmu_tlbr = !dmw_hit && !any_hit;
  assign mmu_pil  = !dmw_hit && any_hit && !sel_valid && !mmu_we;
  assign mmu_pis  = !dmw_hit && any_hit && !sel_valid && mmu_we;
  assign mmu_ppi  = mapped && plv > sel_plv;
  assign mmu_pme  = mapped && plv <= sel_plv && mmu_we && !sel_dirty;

  // The RAM never sees a misaligned or faulting access.
  assign misaligned = mmu_size == 2'd1 && mmu_addr[0]
                      || mmu_size == 2'd2 && mmu_addr[1:0] != 2'b00;

  assign ram_req   = mmu_req && !misaligned
                     && !(mmu_tlbr || mmu_pil || mmu_pis || mmu_ppi || mmu_pme);
  assign ram_addr  = dmw_hit ? {dmw_pseg, mmu_addr[28:0]} : {sel_ppn, mmu_addr[11:0]};
  assign ram_we    = mmu_we;
  assign ram_wstrb = mmu_wstrb;
  assign ram_wdata = mmu_wdata;

  assign mmu_addr_ok = ram_addr_ok;
  assign mmu_data_ok = ram_data_ok;
  assign mmu_rdata   = ram_rdata;

endmodule

// File: rtl/data_ram.sv
`timescale 1ns/1ns

module data_ram #(
  parameter int RAM_WORDS = 1024
) (
  input  logic           clk,
  input  logic           reset,
  input  logic           ram_req,
  input  mem_pkg::word_t ram_addr,
  input  logic           ram_we,
  input  mem_pkg::strb_t ram_wstrb,
  input  mem_pkg::word_t ram_wdata,
  output logic           ram_addr_ok,
  output logic           ram_data_ok,
  output mem_pkg::word_t ram_rdata
);
  import mem_pkg::*;

  localparam int IDX_W = $clog2(RAM_WORDS);

  word_t            mem [RAM_WORDS];
  logic             busy;
  logic [IDX_W-1:0] idx;

  assign idx         = ram_addr[IDX_W+1:2]; // Word index wraps at the depth.
  assign ram_addr_ok = ram_req && !busy;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy        <= 1'b0;
      ram_data_ok <= 1'b0;
    end else begin
      busy        <= ram_addr_ok && ram_we; // One dead cycle after every write.
      ram_data_ok <= ram_addr_ok;
    end
  end

  always_ff @(posedge clk) begin
    if (ram_addr_ok) begin
      ram_rdata <= mem[idx];
      if (ram_we) begin
        for (int b = 0; b < 4; b++) begin
          if (ram_wstrb[b]) begin
            mem[idx][8*b +: 8] <= ram_wdata[8*b +: 8];
          end
        end
      end
    end
  end

endmodule

// File: rtl/mem_subsys_top.sv
`timescale 1ns/1ns

module mem_subsys_top #(
  parameter int RAM_WORDS = 1024
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 cfg_we,
  input  mem_pkg::cfg_idx_t    cfg_idx,
  input  mem_pkg::word_t       cfg_wdata,
  input  logic                 valid,
  input  logic                 start,
  input  logic                 cancel,
  input  mem_pkg::word_t       addr,
  input  mem_pkg::mem_opcode_t opcode,
  input  mem_pkg::word_t       st_data,
  output logic                 ready,
  output logic                 have_excp,
  output mem_pkg::excp_t       excp_type,
  output logic                 ok,
  input  logic                 accept_ok,
  output mem_pkg::word_t       ld_data
);
  import mem_pkg::*;

  localparam int MAP_ENTRIES = 4;

  logic                   mmu_req, mmu_we, mmu_addr_ok, mmu_data_ok;
  logic [1:0]             mmu_size;
  word_t                  mmu_addr, mmu_wdata, mmu_rdata;
  strb_t                  mmu_wstrb;
  logic                   mmu_tlbr, mmu_pil, mmu_pis, mmu_ppi, mmu_pme;
  plv_t                   plv;
  logic                   dmw_en;
  logic [2:0]             dmw_vseg, dmw_pseg;
  vpn_t                   page_vpn [MAP_ENTRIES];
  ppn_t                   page_ppn [MAP_ENTRIES];
  plv_t                   page_plv [MAP_ENTRIES];
  logic [MAP_ENTRIES-1:0] page_valid, page_dirty;
  logic                   ram_req, ram_we, ram_addr_ok, ram_data_ok;
  word_t                  ram_addr, ram_wdata, ram_rdata;
  strb_t                  ram_wstrb;

  lsu u_lsu (.*);

  mmu_csr #(.MAP_ENTRIES(MAP_ENTRIES)) u_mmu_csr (.*);

  mmu #(.MAP_ENTRIES(MAP_ENTRIES)) u_mmu (.*);

  data_ram #(.RAM_WORDS(RAM_WORDS)) u_data_ram (.*);

endmodule

// File: sim/tb_top.sv
`timescale 1ns/1ns

module tb_top;
  import mem_pkg::*;

  localparam int INIT_OPS       = 128;
  localparam int RAND_OPS       = 400;
  localparam int OTHER_OPS      = 16;
  localparam int TIMEOUT_CYCLES = (INIT_OPS + RAND_OPS + OTHER_OPS) * 20;
  localparam mem_opcode_t OPC_SW = mem_opcode_t'((1 << OP_STORE) | (1 << OP_SIZE_WORD));
  localparam mem_opcode_t OPC_LW = mem_opcode_t'(1 << OP_SIZE_WORD);

  logic        clk, reset, cfg_we, valid, start, cancel, accept_ok;
  logic        ready, have_excp, ok;
  cfg_idx_t    cfg_idx;
  word_t       cfg_wdata, addr, st_data, ld_data;
  mem_opcode_t opcode;
  excp_t       excp_type;

  // Testbench copy of the configuration and of the RAM contents.
  plv_t       m_plv;
  logic       m_dmw_en;
  logic [2:0] m_vseg, m_pseg;
  vpn_t       m_vpn [4];
  ppn_t       m_ppn [4];
  plv_t       m_eplv [4];
  logic       m_valid [4];
  logic       m_dirty [4];
  logic [7:0] mem_model [65536];

  string exp_name_q [$];
  word_t exp_data_q [$];
  logic  exp_load_q [$];
  word_t rng = 32'd18528;
  logic  accept_random = 1'b0;
  int    cycles = 0;

  mem_subsys_top #(.RAM_WORDS(16384)) dut (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic word_t lcg_next(input word_t s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic word_t next_rand();
    rng = lcg_next(rng);
    return {8'h00, rng[31:8]};
  endfunction

  // ==================================================
  // Reference models
  // ==================================================
  function automatic void translate(input word_t a, input mem_opcode_t op, output logic exc,
                                    output excp_t code, output word_t pa);
    int hit;
    hit  = -1;
    exc  = 1'b1;
    code = EXC_ALE;
    pa   = '0;
    for (int i = 3; i >= 0; i--) begin
      if (m_vpn[i] == a[31:12]) hit = i;
    end
    if (op[OP_SIZE_HALF] && a[0] || op[OP_SIZE_WORD] && a[1:0] != 2'b00) begin
      code = EXC_ALE;
    end else if (m_dmw_en && a[31:29] == m_vseg) begin
      exc = 1'b0;
      pa  = {m_pseg, a[28:0]};
    end else if (hit < 0) begin
      code = EXC_TLBR;
    end else if (!m_valid[hit]) begin
      code = op[OP_STORE] ? EXC_PIS : EXC_PIL;
    end else if (m_plv > m_eplv[hit]) begin
      code = EXC_PPI;
    end else if (op[OP_STORE] && !m_dirty[hit]) begin
      code = EXC_PME;
    end else begin
      exc = 1'b0;
      pa  = {m_ppn[hit], a[11:0]};
    end
  endfunction

  function automatic word_t expected_load(input mem_opcode_t op, input word_t pa);
    logic [15:0] i;
    logic [15:0] h;
    i = pa[15:0];
    h = {mem_model[i + 1], mem_model[i]};
    if (op[OP_SIZE_BYTE]) return {{24{op[OP_LOAD_SIGN] && mem_model[i][7]}}, mem_model[i]};
    if (op[OP_SIZE_HALF]) return {{16{op[OP_LOAD_SIGN] && h[15]}}, h};
    return {mem_model[i + 3], mem_model[i + 2], h};
  endfunction

  function automatic void store_model(input mem_opcode_t op, input word_t pa, input word_t d);
    logic [15:0] i;
    i = pa[15:0];
    mem_model[i] = d[7:0];
    if (!op[OP_SIZE_BYTE]) mem_model[i + 1] = d[15:8];
    if (op[OP_SIZE_WORD]) begin
      mem_model[i + 2] = d[23:16];
      mem_model[i + 3] = d[31:24];
    end
  endfunction

  // ==================================================
  // Compare tasks
  // ==================================================
  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("Error %s: expected %h, actual %h", name, exp, act);
      $display("ERRORS FOUND");
      $fatal(1, "Stopped at the first mismatch.");
    end
  endtask

  task automatic check_excp(input string name, input excp_t exp, input excp_t act);
    if (exp !== act) begin
      $display("Error %s: expected %0d, actual %0d", name, exp, act);
      $display("ERRORS FOUND");
      $fatal(1, "Stopped at the first mismatch.");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("Error %s: expected %b, actual %b", name, exp, act);
      $display("ERRORS FOUND");
      $fatal(1, "Stopped at the first mismatch.");
    end
  endtask

  // ==================================================
  // Stimulus tasks
  // ==================================================
  task automatic write_cfg(input cfg_idx_t idx, input word_t w);
    @(posedge clk);
    cfg_we    <= 1'b1;
    cfg_idx   <= idx;
    cfg_wdata <= w;
    @(posedge clk);
    cfg_we    <= 1'b0;
  endtask

  task automatic write_page(input int i, input vpn_t vpn, input logic [7:0] ppn,
                            input plv_t eplv, input logic dirty, input logic vld);
    m_vpn[i]   = vpn;
    m_ppn[i]   = ppn_t'(ppn);
    m_eplv[i]  = eplv;
    m_dirty[i] = dirty;
    m_valid[i] = vld;
    write_cfg(cfg_idx_t'(CFG_PAGE0 + i),
              (word_t'(vpn) << PG_VPN_LSB) | (word_t'(ppn) << PG_PPN_LSB)
              | (word_t'(eplv) << PG_PLV_LSB) | (word_t'(dirty) << PG_DIRTY_BIT)
              | (word_t'(vld) << PG_VALID_BIT));
  endtask

  // Starts one access, or only checks its exception when it must fault.
  task automatic do_op(input string name, input mem_opcode_t op, input word_t a, input word_t d);
    logic  exc;
    excp_t code;
    word_t pa;
    translate(a, op, exc, code, pa);
    @(posedge clk);
    valid   <= 1'b1;
    addr    <= a;
    opcode  <= op;
    st_data <= d;
    start   <= !exc;
    cancel  <= 1'b0;
    if (!exc) begin
      exp_name_q.push_back(name);
      exp_load_q.push_back(!op[OP_STORE]);
      exp_data_q.push_back(op[OP_STORE] ? '0 : expected_load(op, pa));
      if (op[OP_STORE]) store_model(op, pa, d);
    end
    @(negedge clk);
    check_bit({name, " have_excp"}, exc, have_excp);
    if (exc) check_excp({name, " excp_type"}, code, excp_type);
    while (!exc && !ready) begin
      @(posedge clk);
      start <= 1'b0; // Inputs stay put until the address is taken.
      @(negedge clk);
    end
  endtask

  task automatic drain();
    @(posedge clk);
    valid  <= 1'b0;
    start  <= 1'b0;
    cancel <= 1'b0;
    while (exp_name_q.size() != 0) @(negedge clk);
    repeat (3) @(posedge clk);
  endtask

  function automatic mem_opcode_t rand_op();
    word_t       r;
    mem_opcode_t op;
    r  = next_rand();
    op = '0;
    case (r % 3)
      0:       op[OP_SIZE_BYTE] = 1'b1;
      1:       op[OP_SIZE_HALF] = 1'b1;
      default: op[OP_SIZE_WORD] = 1'b1;
    endcase
    if (r[8]) op[OP_STORE] = 1'b1;
    else      op[OP_LOAD_SIGN] = r[9];
    return op;
  endfunction

  function automatic word_t rand_addr();
    word_t r;
    r = next_rand();
    case (r[10:8])
      1:       return 32'hA000_1000 | r[7:0];
      2:       return 32'h0001_0000 | r[7:0]; // Page 0, lands in the second pool.
      3:       return 32'h0001_1000 | r[7:0]; // Clean page onto the first pool.
      4:       return 32'h0001_2000 | r[7:0];
      5:       return 32'h0001_3000 | r[7:0];
      6:       return 32'h0002_0000 | r[7:0];
      default: return 32'hA000_0000 | r[7:0];
    endcase
  endfunction

  // ==================================================
  // Processes
  // ==================================================
  initial begin
    word_t s;
    int    hold;
    s    = 32'd18528 ^ 32'h5a5a;
    hold = 0;
    accept_ok = 1'b1;
    forever begin
      @(posedge clk);
      s = lcg_next(s);
      if (hold > 0) hold--;
      else if (accept_random && s[25:24] == 2'b00) hold = 1 + s[20:18];
      accept_ok <= !(accept_random && hold > 0);
    end
  end

  initial begin
    logic  held;
    word_t held_data;
    string nm;
    held = 1'b0;
    held_data = '0;
    forever begin
      @(negedge clk);
      if (!reset) begin
        if (held) begin
          check_bit("ok held", 1'b1, ok);
          check_word("ld_data held", held_data, ld_data);
        end
        held = 1'b0;
        if (ok && accept_ok && exp_name_q.size() == 0) begin
          $display("A result came back with no access outstanding.");
          $display("ERRORS FOUND");
          $fatal(1, "Unexpected result.");
        end else if (ok && accept_ok) begin
          nm = exp_name_q.pop_front();
          if (exp_load_q.pop_front()) check_word(nm, exp_data_q.pop_front(), ld_data);
          else void'(exp_data_q.pop_front());
        end else if (ok) begin
          held      = 1'b1;
          held_data = ld_data;
        end
      end
    end
  end

  initial begin
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
        $display("Timeout: the run hung after %0d cycles.", cycles);
        $display("ERRORS FOUND");
        $fatal(1, "Timeout.");
      end
    end
  end

  initial begin
    reset = 1'b1;
    cfg_we = 1'b0;
    cfg_idx = '0;
    cfg_wdata = '0;
    valid = 1'b0;
    start = 1'b0;
    cancel = 1'b0;
    addr = '0;
    opcode = '0;
    st_data = '0;
    m_plv = '0;
    m_dmw_en = 1'b0;
    m_vseg = '0;
    m_pseg = '0;
    for (int i = 0; i < 4; i++) begin
      m_vpn[i] = '0;
      m_ppn[i] = '0;
      m_eplv[i] = '0;
      m_valid[i] = 1'b0;
      m_dirty[i] = 1'b0;
    end
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_bit("reset ready", 1'b1, ready);
    check_bit("reset ok", 1'b0, ok);

    // Window 0xA0000000 maps onto physical segment 0.
    m_dmw_en = 1'b1;
    m_vseg = 3'd5;
    write_cfg(CFG_DMW, (word_t'(3'd5) << DMW_VSEG_LSB) | word_t'(1));
    for (int w = 0; w < INIT_OPS; w++) begin
      do_op("init", OPC_SW, 32'hA000_0000 + (w / 64) * 32'h1000 + (w % 64) * 4, next_rand());
    end
    drain();

    write_page(0, 20'h00010, 8'h01, 2'd3, 1'b1, 1'b1);
    write_page(1, 20'h00011, 8'h00, 2'd3, 1'b0, 1'b1);
    write_page(2, 20'h00012, 8'h00, 2'd3, 1'b1, 1'b0);
    write_page(3, 20'h00013, 8'h00, 2'd0, 1'b1, 1'b1);
    m_plv = 2'd3;
    write_cfg(CFG_PLV, 32'd3);

    for (int n = 0; n < RAND_OPS; n++) begin
      accept_random = n >= RAND_OPS / 2;
      do_op("random", rand_op(), rand_addr(), next_rand());
    end
    drain();
    accept_random = 1'b0;
    drain();

    // The RAM is busy in the cycle after the store, so the cancelled start is dropped.
    do_op("cancel setup", OPC_SW, 32'hA000_0040, 32'h1234_5678);
    @(posedge clk);
    valid   <= 1'b1;
    addr    <= 32'hA000_0040;
    opcode  <= OPC_SW;
    st_data <= 32'hDEAD_BEEF;
    start   <= 1'b1;
    cancel  <= 1'b1;
    @(posedge clk);
    start   <= 1'b0;
    cancel  <= 1'b0;
    do_op("cancel check", OPC_LW, 32'hA000_0040, '0);
    drain();

    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: flist.f
rtl/mem_pkg.sv
rtl/lsu.sv
rtl/mmu_csr.sv
rtl/mmu.sv
rtl/data_ram.sv
rtl/mem_subsys_top.sv
sim/tb_top.sv

// File: Makefile
SRCS := rtl/mem_pkg.sv rtl/lsu.sv rtl/mmu_csr.sv rtl/mmu.sv rtl/data_ram.sv \
        rtl/mem_subsys_top.sv sim/tb_top.sv

.PHONY: all run clean

all: obj_dir/Vtb_top

obj_dir/Vtb_top: flist.f $(SRCS)
	verilator --binary -j 0 -Wno-fatal --top-module tb_top -f flist.f \
		--Mdir obj_dir -o Vtb_top

run: obj_dir/Vtb_top
	./obj_dir/Vtb_top

clean:
	rm -rf obj_dir
